//--- Makefile
VERILATOR = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP = eth_rx_tb
RTL_TOP = eth_rx_subsystem
FILELIST = eth_rx_subsystem.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/eth_rx_tb.sv
`default_nettype none

module eth_rx_tb;
	import eth_rx_pkg::*;

	localparam int num_frames = 12;
	localparam int word_bytes = word_width / 8;

	// One frame of stimulus, in table order
	typedef struct packed {
		logic [15:0] len;
		logic [mac_addr_width-1:0] dst;
		logic [mac_addr_width-1:0] src;
		logic [ethertype_width-1:0] ethertype;
		logic drop;
		logic [7:0] gap;
	} frame_row_t;

	logic rx_clk;
	logic rx_reset;
	logic mac_start;
	logic mac_data_valid;
	logic [bytes_width-1:0] mac_bytes_valid;
	logic [word_width-1:0] mac_data;
	logic mac_commit;
	logic mac_drop;
	logic sys_clk;
	logic reset;
	logic frame_valid;
	logic runt;
	logic [mac_addr_width-1:0] dst_mac;
	logic [mac_addr_width-1:0] src_mac;
	logic [ethertype_width-1:0] ethertype;
	logic [len_width-1:0] payload_len;
	logic [counter_width-1:0] frames_crossed;

	frame_row_t frame_table [num_frames];
	logic [7:0] frame_bytes [$];
	// Table indices of frames still owed by the DUT
	int exp_q [$];
	int error_count;
	int frames_checked;
	int committed_frames;
	integer seed;
	bit table_loaded;

	eth_rx_subsystem uut (
		.rx_clk(rx_clk),
		.rx_reset(rx_reset),
		.mac_start(mac_start),
		.mac_data_valid(mac_data_valid),
		.mac_bytes_valid(mac_bytes_valid),
		.mac_data(mac_data),
		.mac_commit(mac_commit),
		.mac_drop(mac_drop),
		.sys_clk(sys_clk),
		.reset(reset),
		.frame_valid(frame_valid),
		.runt(runt),
		.dst_mac(dst_mac),
		.src_mac(src_mac),
		.ethertype(ethertype),
		.payload_len(payload_len),
		.frames_crossed(frames_crossed)
	);

	////////////////////////////////////////
	// Two clocks with unrelated periods

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	initial begin
		rx_clk = 1'b0;
		forever #16 rx_clk = ~rx_clk;
	end

	////////////////////////////////////////
	// Frame table and MAC driver

	task automatic load_frame_table();
		// Length, destination, source, ethertype, drop, idle cycles after
		frame_table[0] = '{16'd64, 48'hffffffffffff, 48'h0050c2a1b2c3, 16'h0800, 1'b0, 8'd3};
		frame_table[1] = '{16'd61, 48'h0a1b2c3d4e5f, 48'h02aabbccdd01, 16'h86dd, 1'b0, 8'd2};
		frame_table[2] = '{16'd46, 48'h01005e000001, 48'h02aabbccdd02, 16'h0800, 1'b1, 8'd0};
		frame_table[3] = '{16'd50, 48'h3c7d0a11e2f4, 48'h02aabbccdd03, 16'h0806, 1'b0, 8'd4};
		frame_table[4] = '{16'd10, 48'h112233445566, 48'h665544332211, 16'h0000, 1'b0, 8'd2};
		frame_table[5] = '{16'd13, 48'h8899aabbccdd, 48'hddccbbaa9988, 16'h0000, 1'b0, 8'd0};
		frame_table[6] = '{16'd14, 48'h0e0f10111213, 48'h141516171819, 16'h88cc, 1'b0, 8'd0};
		frame_table[7] = '{16'd15, 48'hfedcba987654, 48'h456789abcdef, 16'h8100, 1'b0, 8'd0};
		frame_table[8] = '{16'd72, 48'h5a5a5a5a5a5a, 48'ha5a5a5a5a5a5, 16'h0800, 1'b1, 8'd0};
		frame_table[9] = '{16'd60, 48'h00a0c9123456, 48'h02aabbccdd0a, 16'h88f7, 1'b0, 8'd0};
		frame_table[10] = '{16'd99, 48'h3333ff000001, 48'h02aabbccdd0b, 16'h86dd, 1'b0, 8'd5};
		frame_table[11] = '{16'd33, 48'h0123456789ab, 48'h02aabbccdd0c, 16'h0842, 1'b0, 8'd3};
		committed_frames = 0;
		// Dropped frames owe nothing downstream
		for (int i = 0; i < num_frames; i++) begin
			if (!frame_table[i].drop) begin
				exp_q.push_back(i);
				committed_frames++;
			end
		end
		table_loaded = 1'b1;
	endtask

	function automatic int table_word_count();
		int words;
		words = 0;
		// Data words plus start and closing strobe
		for (int i = 0; i < num_frames; i++) begin
			words += (int'(frame_table[i].len) + word_bytes - 1) / word_bytes + 2;
		end
		return words;
	endfunction

	// Header bytes from the row and payload from the seeded generator
	task automatic assemble_bytes(input frame_row_t row);
		logic [8*header_bytes-1:0] header;
		integer rnd;
		header = {row.dst, row.src, row.ethertype};
		frame_bytes.delete();
		for (int i = 0; i < int'(row.len); i++) begin
			if (i < header_bytes) begin
				frame_bytes.push_back(header[8*(header_bytes-1-i) +: 8]);
			end else begin
				rnd = $random(seed);
				frame_bytes.push_back(rnd[7:0]);
			end
		end
	endtask

	task automatic drive_cycle(input logic start, input logic valid,
		input logic [bytes_width-1:0] count, input logic [word_width-1:0] word,
		input logic commit, input logic drop);
		@(posedge rx_clk);
		mac_start <= start;
		mac_data_valid <= valid;
		mac_bytes_valid <= count;
		mac_data <= word;
		mac_commit <= commit;
		mac_drop <= drop;
	endtask

	task automatic send_frame(input frame_row_t row);
		logic [word_width-1:0] word;
		int left;
		int idx;
		assemble_bytes(row);
		drive_cycle(1'b1, 1'b0, '0, '0, 1'b0, 1'b0);
		idx = 0;
		while (idx < int'(row.len)) begin
			word = '0;
			left = int'(row.len) - idx;
			// Byte 0 of the word sits in the top byte
			for (int b = 0; b < word_bytes; b++) begin
				if (b < left) begin
					word[word_width-1-8*b -: 8] = frame_bytes[idx+b];
				end
			end
			drive_cycle(1'b0, 1'b1, bytes_width'(left > word_bytes ? word_bytes : left),
				word, 1'b0, 1'b0);
			idx += word_bytes;
		end
		drive_cycle(1'b0, 1'b0, '0, '0, !row.drop, row.drop);
		repeat (row.gap) begin
			drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		end
	endtask

	////////////////////////////////////////
	// Compare tasks

	task automatic mac_compare(input string name, input logic [mac_addr_width-1:0] got,
		input logic [mac_addr_width-1:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic ethertype_compare(input string name,
		input logic [ethertype_width-1:0] got, input logic [ethertype_width-1:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic len_compare(input string name, input logic [len_width-1:0] got,
		input logic [len_width-1:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic flag_compare(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic count_compare(input string name, input logic [counter_width-1:0] got,
		input logic [counter_width-1:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	// Oldest outstanding frame against the result on frame_valid
	task automatic score_frame();
		frame_row_t row;
		int idx;
		int errors_before;
		logic is_runt;
		if (exp_q.size() == 0) begin
			$display("frame_valid pulsed with no committed frame outstanding");
			error_count++;
		end else begin
			idx = exp_q.pop_front();
			row = frame_table[idx];
			errors_before = error_count;
			is_runt = int'(row.len) < header_bytes;
			flag_compare("runt", runt, is_runt);
			// Header of a runt is incomplete
			if (!is_runt) begin
				mac_compare("dst_mac", dst_mac, row.dst);
				mac_compare("src_mac", src_mac, row.src);
				ethertype_compare("ethertype", ethertype, row.ethertype);
				len_compare("payload_len", payload_len, len_width'(int'(row.len) - header_bytes));
			end
			frames_checked++;
			$display("Frame %0d, %0d bytes%s: %s", idx, row.len, is_runt ? ", runt" : "",
				(error_count == errors_before) ? "ok" : "errors");
		end
	endtask

	always @(posedge sys_clk) begin
		if (!reset && frame_valid) begin
			score_frame();
		end
	end

	////////////////////////////////////////
	// Sequence and watchdog

	initial begin
		seed = 64193;
		error_count = 0;
		frames_checked = 0;
		reset = 1'b1;
		rx_reset = 1'b1;
		mac_start = 1'b0;
		mac_data_valid = 1'b0;
		mac_bytes_valid = '0;
		mac_data = '0;
		mac_commit = 1'b0;
		mac_drop = 1'b0;
		load_frame_table();
		// Each reset held two cycles of its own clock
		fork
			begin
				repeat (2) @(posedge sys_clk);
				reset <= 1'b0;
			end
			begin
				repeat (2) @(posedge rx_clk);
				rx_reset <= 1'b0;
			end
		join
		repeat (4) @(posedge rx_clk);
		for (int i = 0; i < num_frames; i++) begin
			send_frame(frame_table[i]);
		end
		drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		while (exp_q.size() != 0) begin
			@(posedge sys_clk);
		end
		// Quiet tail where a leaked dropped frame would show up
		repeat (50) @(posedge sys_clk);
		count_compare("frames_crossed", frames_crossed, counter_width'(committed_frames));
		$display("%0d frames checked of %0d expected, frames_crossed %0d, %0d errors",
			frames_checked, committed_frames, frames_crossed, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (table_loaded);
		limit = 200 * table_word_count();
		repeat (limit) @(posedge sys_clk);
		$display("Watchdog expired after %0d sys_clk cycles, %0d frames never arrived",
			limit, exp_q.size());
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- eth_rx_subsystem.f
src/eth_rx_pkg.sv
src/eth_rx_bus_if.sv
src/rx_frame_fifo.sv
src/rx_clock_crossing.sv
src/eth_header_decoder.sv
src/eth_rx_subsystem.sv
dv/eth_rx_tb.sv

//--- src/eth_header_decoder.sv
`default_nettype none

module eth_header_decoder (
	input logic sys_clk,
	input logic reset,
	eth_rx_bus_if.rx cdc,
	output logic frame_valid,
	output logic runt,
	output logic [eth_rx_pkg::mac_addr_width-1:0] dst_mac,
	output logic [eth_rx_pkg::mac_addr_width-1:0] src_mac,
	output logic [eth_rx_pkg::ethertype_width-1:0] ethertype,
	output logic [eth_rx_pkg::len_width-1:0] payload_len
);
	import eth_rx_pkg::*;

	// Word position in the frame, saturates once past the header
	logic [2:0] word_idx;

	// Set once the last ethertype byte has arrived
	logic hdr_done;

	////////////////////////////////////////
	// Header fields

	always_ff @(posedge sys_clk) begin
		if (cdc.data_valid) begin
			case (word_idx)
				// Destination MAC, upper four bytes
				3'd0: begin
					dst_mac[mac_addr_width-1 -: word_width] <= cdc.data;
				end
				// Destination MAC tail and source MAC head share this word
				3'd1: begin
					dst_mac[mac_addr_width-word_width-1:0] <=
						cdc.data[word_width-1 -: mac_addr_width-word_width];
					src_mac[mac_addr_width-1 -: mac_addr_width-word_width] <=
						cdc.data[mac_addr_width-word_width-1:0];
				end
				3'd2: begin
					src_mac[word_width-1:0] <= cdc.data;
				end
				// Ethertype in the top half, payload starts below it
				3'd3: begin
					ethertype <= cdc.data[word_width-1 -: ethertype_width];
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Frame control and length

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			word_idx <= '0;
			hdr_done <= 1'b0;
			payload_len <= '0;
			frame_valid <= 1'b0;
			runt <= 1'b0;
		end else begin
			// Result one clock after commit
			frame_valid <= cdc.commit;
			runt <= cdc.commit && !hdr_done;

			if (cdc.start) begin
				word_idx <= '0;
				hdr_done <= 1'b0;
				payload_len <= '0;
			end else if (cdc.data_valid) begin
				if (word_idx != 3'd4) begin
					word_idx <= word_idx + 1'b1;
				end
				if (word_idx == 3'd3) begin
					// Two ethertype bytes complete the header
					if (cdc.bytes_valid >= 3'd2) begin
						hdr_done <= 1'b1;
					end
					if (cdc.bytes_valid > 3'd2) begin
						payload_len <= payload_len + len_width'(cdc.bytes_valid - 3'd2);
					end
				end else if (word_idx == 3'd4) begin
					payload_len <= payload_len + len_width'(cdc.bytes_valid);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/eth_rx_bus_if.sv
`default_nettype none

interface eth_rx_bus_if;
	import eth_rx_pkg::*;

	// Pulse before the first word of a frame
	logic start;

	// One word per data_valid
	logic data_valid;
	logic [bytes_width-1:0] bytes_valid;
	logic [word_width-1:0] data;

	// Exactly one of these closes each frame
	logic commit;
	logic drop;

	// Producer side
	modport tx (output start, data_valid, bytes_valid, data, commit, drop);

	// Consumer side
	modport rx (input start, data_valid, bytes_valid, data, commit, drop);

endinterface

`default_nettype wire

//--- src/eth_rx_pkg.sv
`default_nettype none

package eth_rx_pkg;

	////////////////////////////////////////
	// Word stream

	// One MAC word, packed from byte 0 in the MSB
	localparam int word_width = 32;

	// Bytes valid in a word, 0 to 4
	// Zero never occurs on data, so it marks a frame delimiter
	localparam int bytes_width = 3;

	////////////////////////////////////////
	// Packet FIFO

	// Entry is bytes valid on top of the data word
	localparam int fifo_width = bytes_width + word_width;

	// Room for two maximum size frames
	localparam int fifo_depth = 1024;
	localparam int fifo_addr_width = $clog2(fifo_depth);

	////////////////////////////////////////
	// Layer 2 header

	// Destination, source and ethertype
	localparam int header_bytes = 14;
	localparam int mac_addr_width = 48;
	localparam int ethertype_width = 16;

	// Payload byte count, enough for a jumbo-free frame
	localparam int len_width = 11;

	// Frames crossed into sys_clk
	localparam int counter_width = 64;

endpackage

`default_nettype wire

//--- src/eth_rx_subsystem.sv
`default_nettype none

module eth_rx_subsystem (
	input logic rx_clk,
	input logic rx_reset,
	input logic mac_start,
	input logic mac_data_valid,
	input logic [eth_rx_pkg::bytes_width-1:0] mac_bytes_valid,
	input logic [eth_rx_pkg::word_width-1:0] mac_data,
	input logic mac_commit,
	input logic mac_drop,
	input logic sys_clk,
	input logic reset,
	output logic frame_valid,
	output logic runt,
	output logic [eth_rx_pkg::mac_addr_width-1:0] dst_mac,
	output logic [eth_rx_pkg::mac_addr_width-1:0] src_mac,
	output logic [eth_rx_pkg::ethertype_width-1:0] ethertype,
	output logic [eth_rx_pkg::len_width-1:0] payload_len,
	output logic [eth_rx_pkg::counter_width-1:0] frames_crossed
);

	// MAC side, rx_clk
	eth_rx_bus_if mac_bus ();

	// Decoder side, sys_clk
	eth_rx_bus_if cdc_bus ();

	assign mac_bus.start = mac_start;
	assign mac_bus.data_valid = mac_data_valid;
	assign mac_bus.bytes_valid = mac_bytes_valid;
	assign mac_bus.data = mac_data;
	assign mac_bus.commit = mac_commit;
	assign mac_bus.drop = mac_drop;

	rx_clock_crossing crossing (
		.rx_clk(rx_clk),
		.rx_reset(rx_reset),
		.sys_clk(sys_clk),
		.reset(reset),
		.mac(mac_bus.rx),
		.cdc(cdc_bus.tx),
		.frames_crossed(frames_crossed)
	);

	eth_header_decoder decoder (
		.sys_clk(sys_clk),
		.reset(reset),
		.cdc(cdc_bus.rx),
		.frame_valid(frame_valid),
		.runt(runt),
		.dst_mac(dst_mac),
		.src_mac(src_mac),
		.ethertype(ethertype),
		.payload_len(payload_len)
	);

endmodule

`default_nettype wire

//--- src/rx_clock_crossing.sv
`default_nettype none

module rx_clock_crossing (
	input logic rx_clk,
	input logic rx_reset,
	input logic sys_clk,
	input logic reset,
	eth_rx_bus_if.rx mac,
	eth_rx_bus_if.tx cdc,
	output logic [eth_rx_pkg::counter_width-1:0] frames_crossed
);
	import eth_rx_pkg::*;

	logic push;
	logic overflow;
	logic fifo_wr_en;
	logic [fifo_width-1:0] fifo_wr_data;
	logic fifo_wr_full;
	logic fifo_commit;
	logic fifo_rollback;

	logic fifo_rd_en;
	logic fifo_rd_pop;
	logic [fifo_width-1:0] fifo_rd_data;
	logic [fifo_addr_width:0] fifo_rd_size;
	logic [bytes_width-1:0] rd_bytes;
	logic [word_width-1:0] rd_word;

	rx_frame_fifo rx_fifo (
		.rx_clk(rx_clk),
		.rx_reset(rx_reset),
		.wr_en(fifo_wr_en),
		.wr_data(fifo_wr_data),
		.wr_commit(fifo_commit),
		.wr_rollback(fifo_rollback),
		.wr_full(fifo_wr_full),
		.sys_clk(sys_clk),
		.reset(reset),
		.rd_en(fifo_rd_en),
		.rd_pop(fifo_rd_pop),
		.rd_data(fifo_rd_data),
		.rd_size(fifo_rd_size)
	);

	////////////////////////////////////////
	// Push side, rx_clk

	// All-zero word on start marks the frame boundary
	always_comb begin
		push = mac.start | mac.data_valid;
		fifo_wr_en = push && !fifo_wr_full && !overflow;
		if (mac.start) begin
			fifo_wr_data = '0;
		end else begin
			fifo_wr_data = {mac.bytes_valid, mac.data};
		end
	end

	// Once full, the rest of the frame is lost
	always_ff @(posedge rx_clk) begin
		if (rx_reset) begin
			overflow <= 1'b0;
		end else if (mac.commit || mac.drop) begin
			overflow <= 1'b0;
		end else if (push && fifo_wr_full) begin
			overflow <= 1'b1;
		end
	end

	// A truncated frame is rolled back like a MAC drop
	assign fifo_commit = mac.commit && !overflow;
	assign fifo_rollback = mac.drop || (mac.commit && overflow);

	////////////////////////////////////////
	// Pop side, sys_clk

	logic rd_valid;
	logic look_valid;
	logic word_ready;
	logic fifo_avail;

	enum logic [2:0] {
		st_sync,
		st_sync_wait,
		st_sync_check,
		st_idle,
		st_frame
	} pop_state;

	assign {rd_bytes, rd_word} = fifo_rd_data;

	// Words left after any pop already under way
	assign fifo_avail = fifo_rd_size > {{fifo_addr_width{1'b0}}, fifo_rd_pop};

	// Fresh read data, or a held word of the next frame
	assign word_ready = rd_valid || look_valid;

	// Nothing is ever dropped past the FIFO
	assign cdc.drop = 1'b0;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			pop_state <= st_sync;
			fifo_rd_en <= 1'b0;
			fifo_rd_pop <= 1'b0;
			rd_valid <= 1'b0;
			look_valid <= 1'b0;
			cdc.start <= 1'b0;
			cdc.data_valid <= 1'b0;
			cdc.commit <= 1'b0;
			frames_crossed <= '0;
		end else begin
			fifo_rd_en <= 1'b0;
			fifo_rd_pop <= 1'b0;
			cdc.start <= 1'b0;
			cdc.data_valid <= 1'b0;
			cdc.commit <= 1'b0;
			// Read data lands one clock after the FIFO sees rd_en
			rd_valid <= fifo_rd_en;

			case (pop_state)
				// Peek the head word and wait out the RAM latency
				st_sync: begin
					if (fifo_avail) begin
						fifo_rd_en <= 1'b1;
						pop_state <= st_sync_wait;
					end
				end
				st_sync_wait: begin
					pop_state <= st_sync_check;
				end
				// Head must be a delimiter or it is discarded
				st_sync_check: begin
					fifo_rd_pop <= 1'b1;
					if (rd_bytes == '0) begin
						pop_state <= st_idle;
					end else begin
						pop_state <= st_sync;
					end
				end

				// Any committed word here is a whole frame
				st_idle: begin
					if (look_valid || fifo_avail) begin
						cdc.start <= 1'b1;
						if (!look_valid) begin
							fifo_rd_en <= 1'b1;
							fifo_rd_pop <= 1'b1;
						end
						pop_state <= st_frame;
					end
				end

				st_frame: begin
					if (word_ready && rd_bytes == '0) begin
						// Next delimiter closes this frame
						// A read in flight is the first word of the next one
						cdc.commit <= 1'b1;
						frames_crossed <= frames_crossed + 1'b1;
						look_valid <= fifo_rd_en;
						pop_state <= st_idle;
					end else begin
						if (word_ready) begin
							cdc.data_valid <= 1'b1;
							cdc.bytes_valid <= rd_bytes;
							cdc.data <= rd_word;
							look_valid <= 1'b0;
						end
						// One word per clock while committed data lasts
						if (fifo_avail) begin
							fifo_rd_en <= 1'b1;
							fifo_rd_pop <= 1'b1;
						end else if (!word_ready && !fifo_rd_en) begin
							// FIFO drained at a commit boundary so the frame is complete
							cdc.commit <= 1'b1;
							frames_crossed <= frames_crossed + 1'b1;
							pop_state <= st_sync;
						end
					end
				end

				default: begin
					pop_state <= st_sync;
				end
			endcase
		end
	end

	// Decoder needs at least one clock between start and commit
	cdc_start_commit_apart: assert property (@(posedge sys_clk) disable iff (reset)
		cdc.start |=> !cdc.commit);

endmodule

`default_nettype wire

//--- src/rx_frame_fifo.sv
`default_nettype none

module rx_frame_fifo (
	input logic rx_clk,
	input logic rx_reset,
	input logic wr_en,
	input logic [eth_rx_pkg::fifo_width-1:0] wr_data,
	input logic wr_commit,
	input logic wr_rollback,
	output logic wr_full,
	input logic sys_clk,
	input logic reset,
	input logic rd_en,
	input logic rd_pop,
	output logic [eth_rx_pkg::fifo_width-1:0] rd_data,
	output logic [eth_rx_pkg::fifo_addr_width:0] rd_size
);
	import eth_rx_pkg::*;

	// Block RAM, no reset
	logic [fifo_width-1:0] mem [fifo_depth];

	// Write side pointers, one extra bit for wrap
	logic [fifo_addr_width:0] wr_ptr;
	logic [fifo_addr_width:0] wr_ptr_next;
	logic [fifo_addr_width:0] commit_ptr;
	logic [fifo_addr_width:0] commit_gray;
	logic [fifo_addr_width:0] rd_gray_meta;
	logic [fifo_addr_width:0] rd_gray_sync;
	logic [fifo_addr_width:0] rd_ptr_wr;

	// Read side pointers
	logic [fifo_addr_width:0] rd_ptr;
	logic [fifo_addr_width:0] rd_gray;
	logic [fifo_addr_width:0] commit_gray_meta;
	logic [fifo_addr_width:0] commit_gray_sync;
	logic [fifo_addr_width:0] commit_ptr_rd;

	function automatic logic [fifo_addr_width:0] bin2gray(input logic [fifo_addr_width:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	function automatic logic [fifo_addr_width:0] gray2bin(input logic [fifo_addr_width:0] gray);
		logic [fifo_addr_width:0] bin;
		bin[fifo_addr_width] = gray[fifo_addr_width];
		for (int i = fifo_addr_width - 1; i >= 0; i--) begin
			bin[i] = bin[i + 1] ^ gray[i];
		end
		return bin;
	endfunction

	////////////////////////////////////////
	// Write side, rx_clk

	// Full counts tentative words too
	assign rd_ptr_wr = gray2bin(rd_gray_sync);
	assign wr_full = (wr_ptr[fifo_addr_width] != rd_ptr_wr[fifo_addr_width]) &&
		(wr_ptr[fifo_addr_width-1:0] == rd_ptr_wr[fifo_addr_width-1:0]);

	assign wr_ptr_next = wr_en ? wr_ptr + 1'b1 : wr_ptr;

	always_ff @(posedge rx_clk) begin
		if (wr_en) begin
			mem[wr_ptr[fifo_addr_width-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (rx_reset) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			commit_gray <= '0;
		end else if (wr_rollback) begin
			// Throw away everything since the last commit
			wr_ptr <= commit_ptr;
		end else begin
			wr_ptr <= wr_ptr_next;
			// Publish the frame, Gray copy is registered so it never glitches
			if (wr_commit) begin
				commit_ptr <= wr_ptr_next;
				commit_gray <= bin2gray(wr_ptr_next);
			end
		end
	end

	// Read pointer into rx_clk
	always_ff @(posedge rx_clk) begin
		if (rx_reset) begin
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
		end else begin
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
		end
	end

	////////////////////////////////////////
	// Read side, sys_clk

	// Committed pointer into sys_clk
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			commit_gray_meta <= '0;
			commit_gray_sync <= '0;
		end else begin
			commit_gray_meta <= commit_gray;
			commit_gray_sync <= commit_gray_meta;
		end
	end

	// Only committed words count
	assign commit_ptr_rd = gray2bin(commit_gray_sync);
	assign rd_size = commit_ptr_rd - rd_ptr;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			rd_ptr <= '0;
			rd_gray <= '0;
		end else if (rd_pop) begin
			rd_ptr <= rd_ptr + 1'b1;
			rd_gray <= bin2gray(rd_ptr + 1'b1);
		end
	end

	// Registered read at the current head
	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_ptr[fifo_addr_width-1:0]];
		end
	end

	// Writer must drop the frame rather than push into a full FIFO
	wr_no_overflow: assert property (@(posedge rx_clk) disable iff (rx_reset)
		wr_en |-> !wr_full);

	// Popper must only consume committed words
	rd_no_underflow: assert property (@(posedge sys_clk) disable iff (reset)
		rd_pop |-> rd_size != '0);

endmodule

`default_nettype wire
